// ==== Makefile ====
# Verilator simulation of the MIPS32 subset core.

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_instr_valid,
    input  wire   [DATA_W-1:0] i_instr,
    wb_if.dst                  wb,
    id_ex_if.src               id_ex
);

    opcode_e               op;
    funct_e                fn;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [IMM_W-1:0]      imm16;

    ctrl_t                 ctrl_c;
    logic                  legal_c;
    logic [DATA_W-1:0]     imm_c;
    logic [REG_ADDR_W-1:0] dest_c;
    logic [DATA_W-1:0]     rs_data_c;
    logic [DATA_W-1:0]     rt_data_c;

    logic [DATA_W-1:0]     regs [NUM_REGS];
    logic                  rf_we;

    assign op      = opcode_e'(i_instr[OPCODE_LSB +: OPCODE_W]);
    assign fn      = funct_e'(i_instr[FUNCT_LSB +: FUNCT_W]);
    assign rs_addr = i_instr[RS_LSB +: REG_ADDR_W];
    assign rt_addr = i_instr[RT_LSB +: REG_ADDR_W];
    assign rd_addr = i_instr[RD_LSB +: REG_ADDR_W];
    assign imm16   = i_instr[IMM_LSB +: IMM_W];

    always_comb
    begin
        ctrl_c  = '{alu_op: ALU_ADD, default: 1'b0};
        legal_c = 1'b1;
        case (op)
            OP_R_TYPE:
            begin
                ctrl_c.reg_write = 1'b1;
                case (fn)
                    FN_ADDU: ctrl_c.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_c.alu_op = ALU_SUB;
                    FN_AND:  ctrl_c.alu_op = ALU_AND;
                    FN_OR:   ctrl_c.alu_op = ALU_OR;
                    FN_XOR:  ctrl_c.alu_op = ALU_XOR;
                    FN_SLT:  ctrl_c.alu_op = ALU_SLT;
                    default: legal_c = 1'b0;
                endcase
            end
            OP_ADDIU:
            begin
                ctrl_c.alu_src_imm = 1'b1;
                ctrl_c.reg_write   = 1'b1;
            end
            OP_ANDI, OP_ORI:
            begin
                ctrl_c.alu_op       = (op == OP_ANDI) ? ALU_AND : ALU_OR;
                ctrl_c.alu_src_imm  = 1'b1;
                ctrl_c.imm_zero_ext = 1'b1;
                ctrl_c.reg_write    = 1'b1;
            end
            OP_LUI:
            begin
                ctrl_c.alu_op       = ALU_LUI;
                ctrl_c.alu_src_imm  = 1'b1;
                ctrl_c.imm_zero_ext = 1'b1;
                ctrl_c.reg_write    = 1'b1;
            end
            OP_LW:
            begin
                ctrl_c.alu_src_imm = 1'b1;
                ctrl_c.mem_read    = 1'b1;
                ctrl_c.mem_to_reg  = 1'b1;
                ctrl_c.reg_write   = 1'b1;
            end
            OP_SW:
            begin
                ctrl_c.alu_src_imm = 1'b1;
                ctrl_c.mem_write   = 1'b1;
            end
            default: legal_c = 1'b0;                // Unknown encodings leave as a bubble.
        endcase
    end

    assign imm_c  = ctrl_c.imm_zero_ext ? {{(DATA_W-IMM_W){1'b0}}, imm16}
                                        : {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign dest_c = (op == OP_R_TYPE) ? rd_addr : rt_addr;

    // A write in flight this cycle is seen by the read ports.
    assign rs_data_c = (rs_addr == '0) ? '0 :
                       (wb.valid && (wb.dest == rs_addr)) ? wb.data : regs[rs_addr];
    assign rt_data_c = (rt_addr == '0) ? '0 :
                       (wb.valid && (wb.dest == rt_addr)) ? wb.data : regs[rt_addr];

    assign rf_we = wb.valid && (wb.dest != '0);

    always_ff @(posedge i_clk)
    begin
        if (rf_we)
            regs[wb.dest] <= wb.data;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            id_ex.valid <= 1'b0;
        else
            id_ex.valid <= i_instr_valid && legal_c;
    end

    always_ff @(posedge i_clk)
    begin
        id_ex.ctrl    <= ctrl_c;
        id_ex.rs_data <= rs_data_c;
        id_ex.rt_data <= rt_data_c;
        id_ex.imm     <= imm_c;
        id_ex.dest    <= dest_c;
    end

    // A valid write must name a known register for the register 0 guard to hold.
    a_wb_dest_known : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wb.valid |-> !$isunknown(wb.dest));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_rst_n,
    id_ex_if.dst     id_ex,
    ex_mem_if.src    ex_mem
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_y;
    logic              lt_signed;

    assign op_a = id_ex.rs_data;
    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_data;

    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_XOR: alu_y = op_a ^ op_b;
            ALU_SLT: alu_y = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_LUI: alu_y = op_b << IMM_W;      // Immediate goes to the upper half.
            default: alu_y = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            ex_mem.valid <= 1'b0;
        else
            ex_mem.valid <= id_ex.valid;
    end

    always_ff @(posedge i_clk)
    begin
        ex_mem.ctrl       <= id_ex.ctrl;
        ex_mem.alu_result <= alu_y;
        ex_mem.store_data <= id_ex.rt_data;       // SW stores rt.
        ex_mem.dest       <= id_ex.dest;
    end

    // Decode must never hand a load that is also a store to the memory stage.
    a_mem_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        id_ex.valid |-> !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write));

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;

    // Bit positions of the instruction fields.
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;

    typedef enum logic [OPCODE_W-1:0]
    {
        OP_R_TYPE = 6'h00,
        OP_ADDIU  = 6'h09,
        OP_ANDI   = 6'h0c,
        OP_ORI    = 6'h0d,
        OP_LUI    = 6'h0f,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opcode_e;

    // Function codes of the supported R-type instructions.
    typedef enum logic [FUNCT_W-1:0]
    {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

// ==== hw/mips_core.sv ====
`default_nettype none

module mips_core
    import isa_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_instr_valid,
    input  wire   [DATA_W-1:0]     i_instr,
    output logic                   o_wb_valid,
    output logic  [REG_ADDR_W-1:0] o_wb_dest,
    output logic  [DATA_W-1:0]     o_wb_data
);

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();
    wb_if     wb_bus ();

    decode_stage u_decode_stage
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .wb            (wb_bus.dst),
        .id_ex         (id_ex_bus.src)
    );

    execute_stage u_execute_stage
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .id_ex   (id_ex_bus.dst),
        .ex_mem  (ex_mem_bus.src)
    );

    result_stage u_result_stage
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .ex_mem  (ex_mem_bus.dst),
        .wb      (wb_bus.src)
    );

    assign o_wb_valid = wb_bus.valid;
    assign o_wb_dest  = wb_bus.dest;
    assign o_wb_data  = wb_bus.data;

endmodule

`default_nettype wire

// ==== hw/pipe_if.sv ====
`default_nettype none

interface id_ex_if
    import isa_pkg::*, pipe_pkg::*;
();

    logic                  valid;
    ctrl_t                 ctrl;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;
    logic [DATA_W-1:0]     imm;                    // Already sign or zero extended.
    logic [REG_ADDR_W-1:0] dest;

    modport src
    (
        output valid,
        output ctrl,
        output rs_data,
        output rt_data,
        output imm,
        output dest
    );

    modport dst
    (
        input valid,
        input ctrl,
        input rs_data,
        input rt_data,
        input imm,
        input dest
    );

endinterface

interface ex_mem_if
    import isa_pkg::*, pipe_pkg::*;
();

    logic                  valid;
    ctrl_t                 ctrl;
    logic [DATA_W-1:0]     alu_result;
    logic [DATA_W-1:0]     store_data;
    logic [REG_ADDR_W-1:0] dest;

    modport src
    (
        output valid,
        output ctrl,
        output alu_result,
        output store_data,
        output dest
    );

    modport dst
    (
        input valid,
        input ctrl,
        input alu_result,
        input store_data,
        input dest
    );

endinterface

interface wb_if
    import isa_pkg::*;
();

    logic                  valid;                  // A register write is pending.
    logic [REG_ADDR_W-1:0] dest;
    logic [DATA_W-1:0]     data;

    modport src
    (
        output valid,
        output dest,
        output data
    );

    modport dst
    (
        input valid,
        input dest,
        input data
    );

endinterface

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    localparam int ALU_OP_W     = 3;

    localparam int DMEM_WORDS   = 64;
    localparam int DMEM_ADDR_W  = 6;
    localparam int BYTE_OFF_W   = 2;               // Byte offset inside a word.

    // Cycles from the sampling edge to the writeback outputs.
    localparam int PIPE_LATENCY = 3;

    typedef enum logic [ALU_OP_W-1:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    typedef struct packed
    {
        alu_op_e alu_op;
        logic    alu_src_imm;                      // Second operand is the immediate.
        logic    imm_zero_ext;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;                       // Writeback takes the memory word.
        logic    reg_write;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hw/result_stage.sv ====
`default_nettype none

module result_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_rst_n,
    ex_mem_if.dst    ex_mem,
    wb_if.src        wb
);

    logic [DATA_W-1:0]      dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] word_addr;
    logic                   mem_access;

    // Memory/writeback register.
    logic [DATA_W-1:0]      alu_q;
    logic [DATA_W-1:0]      mem_q;
    logic [REG_ADDR_W-1:0]  dest_q;
    logic                   mem_to_reg_q;
    logic                   reg_write_q;

    assign word_addr  = ex_mem.alu_result[BYTE_OFF_W +: DMEM_ADDR_W];
    assign mem_access = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

    always_ff @(posedge i_clk)
    begin
        if (ex_mem.valid && ex_mem.ctrl.mem_write)
            dmem[word_addr] <= ex_mem.store_data;
    end

    always_ff @(posedge i_clk)
    begin
        mem_q        <= dmem[word_addr];           // Synchronous read.
        alu_q        <= ex_mem.alu_result;
        dest_q       <= ex_mem.dest;
        mem_to_reg_q <= ex_mem.ctrl.mem_to_reg;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            reg_write_q <= 1'b0;
        else
            reg_write_q <= ex_mem.valid && ex_mem.ctrl.reg_write;
    end

    assign wb.valid = reg_write_q;
    assign wb.dest  = dest_q;
    assign wb.data  = mem_to_reg_q ? mem_q : alu_q;   // Loads return the memory word.

    a_addr_ok : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        mem_access |-> ((ex_mem.alu_result[BYTE_OFF_W-1:0] == '0) &&
                        (ex_mem.alu_result < DATA_W'(DMEM_WORDS << BYTE_OFF_W))));

endmodule

`default_nettype wire

// ==== mips_core.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_if.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/mips_core.sv
verification/wb_checker.sv
verification/tb_mips_core.sv

// ==== verification/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core
    import isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NAME_BITS     = 128;
    localparam int RESET_CYCLES  = 3;
    localparam int IDLE_CYCLES   = 4;
    localparam int MARGIN_CYCLES = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [DATA_W-1:0]     instr;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic [DATA_W-1:0]     wb_data;

    logic                  exp_issue;
    logic [NAME_BITS-1:0]  exp_name;
    logic                  exp_valid;
    logic [REG_ADDR_W-1:0] exp_dest;
    logic [DATA_W-1:0]     exp_data;

    int                    tests_done;
    int                    tests_failed;
    int                    stray_errors;
    logic                  table_ready;

    logic [NAME_BITS-1:0]  row_name  [$];
    logic [DATA_W-1:0]     row_instr [$];
    int                    row_gap   [$];              // Idle cycles after the row.
    logic                  row_valid [$];
    logic [REG_ADDR_W-1:0] row_dest  [$];
    logic [DATA_W-1:0]     row_data  [$];

    // Architectural state that the expected values are worked out from.
    logic [DATA_W-1:0]     model_regs [NUM_REGS];
    logic [DATA_W-1:0]     model_mem  [DMEM_WORDS];

    mips_core u_mips_core
    (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_wb_valid    (wb_valid),
        .o_wb_dest     (wb_dest),
        .o_wb_data     (wb_data)
    );

    wb_checker #(.NAME_BITS(NAME_BITS)) u_wb_checker
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_issue        (exp_issue),
        .i_name         (exp_name),
        .i_exp_valid    (exp_valid),
        .i_exp_dest     (exp_dest),
        .i_exp_data     (exp_data),
        .i_wb_valid     (wb_valid),
        .i_wb_dest      (wb_dest),
        .i_wb_data      (wb_data),
        .o_tests_done   (tests_done),
        .o_tests_failed (tests_failed),
        .o_stray_errors (stray_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] sign_ext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic push_row(input logic [NAME_BITS-1:0] name, input logic [DATA_W-1:0] word,
                            input int gap, input logic wb, input logic [REG_ADDR_W-1:0] dest,
                            input logic [DATA_W-1:0] data);
        row_name.push_back(name);
        row_instr.push_back(word);
        row_gap.push_back(gap);
        row_valid.push_back(wb);
        row_dest.push_back(dest);
        row_data.push_back(data);
    endtask

    task automatic add_r(input logic [NAME_BITS-1:0] name, input funct_e fn,
                         input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs,
                         input logic [REG_ADDR_W-1:0] rt, input int gap);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] y;
        a = model_regs[rs];
        b = model_regs[rt];
        case (fn)
            FN_ADDU: y = a + b;
            FN_SUBU: y = a - b;
            FN_AND:  y = a & b;
            FN_OR:   y = a | b;
            FN_XOR:  y = a ^ b;
            FN_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: y = '0;
        endcase
        if (rd != '0)
            model_regs[rd] = y;                        // Register 0 stays zero.
        push_row(name, {OP_R_TYPE, rs, rt, rd, 5'd0, fn}, gap, 1'b1, rd, y);
    endtask

    task automatic add_i(input logic [NAME_BITS-1:0] name, input opcode_e op,
                         input logic [REG_ADDR_W-1:0] rt, input logic [REG_ADDR_W-1:0] rs,
                         input logic [15:0] imm, input int gap);
        logic [DATA_W-1:0] base;
        logic [DATA_W-1:0] sum;
        logic [DATA_W-1:0] y;
        logic              writes;
        base   = model_regs[rs];
        sum    = base + sign_ext16(imm);
        writes = 1'b1;
        case (op)
            OP_ADDIU: y = sum;
            OP_ANDI:  y = base & {16'h0000, imm};
            OP_ORI:   y = base | {16'h0000, imm};
            OP_LUI:   y = {imm, 16'h0000};
            OP_LW:    y = model_mem[sum[BYTE_OFF_W +: DMEM_ADDR_W]];
            OP_SW:
            begin
                model_mem[sum[BYTE_OFF_W +: DMEM_ADDR_W]] = model_regs[rt];
                y      = '0;
                writes = 1'b0;
            end
            default:
            begin
                y      = '0;
                writes = 1'b0;
            end
        endcase
        if (writes && (rt != '0))
            model_regs[rt] = y;
        push_row(name, {op, rs, rt, imm}, gap, writes, writes ? rt : 5'd0, y);
    endtask

    // A gap of 2 puts a dependent instruction at the distance of 3.
    task automatic build_table();
        model_regs[0] = '0;
        add_i("addiu_r1", OP_ADDIU, 5'd1, 5'd0, 16'h0123, 2);
        add_i("addiu_r2_neg", OP_ADDIU, 5'd2, 5'd0, 16'hfff0, 2);
        add_i("lui_r3", OP_LUI, 5'd3, 5'd0, 16'h1234, 2);
        add_i("ori_r4_zext", OP_ORI, 5'd4, 5'd0, 16'h8001, 2);
        add_i("ori_r3", OP_ORI, 5'd3, 5'd3, 16'h5678, 2);
        add_i("andi_r5_zext", OP_ANDI, 5'd5, 5'd2, 16'h80f0, 2);
        add_r("addu_r6", FN_ADDU, 5'd6, 5'd1, 5'd5, 2);
        add_r("subu_r7", FN_SUBU, 5'd7, 5'd6, 5'd3, 2);
        add_r("and_r8", FN_AND, 5'd8, 5'd3, 5'd7, 2);
        add_r("or_r9", FN_OR, 5'd9, 5'd1, 5'd8, 2);
        add_r("xor_r10", FN_XOR, 5'd10, 5'd9, 5'd2, 2);
        add_r("slt_neg_lt_pos", FN_SLT, 5'd11, 5'd10, 5'd1, 2);
        add_r("slt_pos_lt_neg", FN_SLT, 5'd12, 5'd11, 5'd2, 2);
        add_i("sw_r3_a08", OP_SW, 5'd3, 5'd0, 16'h0008, 2);
        add_i("lw_r13_a08", OP_LW, 5'd13, 5'd0, 16'h0008, 2);
        add_i("sw_r6_afc", OP_SW, 5'd6, 5'd0, 16'h00fc, 2);
        add_i("lw_r14_afc", OP_LW, 5'd14, 5'd0, 16'h00fc, 2);
        add_i("addiu_r0", OP_ADDIU, 5'd0, 5'd1, 16'h0005, 2);
        add_r("addu_r15_r0", FN_ADDU, 5'd15, 5'd0, 5'd0, 2);
        add_i("b2b_addiu_r16", OP_ADDIU, 5'd16, 5'd0, 16'($urandom()), 0);
        add_i("b2b_ori_r17", OP_ORI, 5'd17, 5'd0, 16'($urandom()), 0);
        add_i("b2b_addiu_r18", OP_ADDIU, 5'd18, 5'd0, 16'($urandom()), 0);
        add_i("b2b_ori_r19", OP_ORI, 5'd19, 5'd0, 16'($urandom()), 0);
        add_i("b2b_addiu_r20", OP_ADDIU, 5'd20, 5'd0, 16'($urandom()), 0);
        add_i("b2b_ori_r21", OP_ORI, 5'd21, 5'd0, 16'($urandom()), 0);
        add_r("addu_r22", FN_ADDU, 5'd22, 5'd16, 5'd17, 2);
    endtask

    initial
    begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_issue   = 1'b0;
        exp_name    = '0;
        exp_valid   = 1'b0;
        exp_dest    = '0;
        exp_data    = '0;
        table_ready = 1'b0;
        void'($urandom(32'h368d));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);           // Any writeback here is flagged.
        for (int r = 0; r < row_name.size(); r++)
        begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= row_instr[r];
            exp_issue   <= 1'b1;
            exp_name    <= row_name[r];
            exp_valid   <= row_valid[r];
            exp_dest    <= row_dest[r];
            exp_data    <= row_data[r];
            for (int g = 0; g < row_gap[r]; g++)
            begin
                @(posedge clk);
                instr_valid <= 1'b0;
                exp_issue   <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        exp_issue   <= 1'b0;
        wait (tests_done == row_name.size());
        repeat (PIPE_LATENCY + 1) @(posedge clk);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d unexpected writebacks",
                 tests_done, tests_done - tests_failed, tests_failed, stray_errors);
        if ((tests_failed == 0) && (stray_errors == 0))
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int max_gap;
        int limit;
        wait (table_ready);
        max_gap = 0;
        foreach (row_gap[i])
            if (row_gap[i] > max_gap)
                max_gap = row_gap[i];
        limit = row_name.size() * (max_gap + 1) + RESET_CYCLES + IDLE_CYCLES
                + PIPE_LATENCY + MARGIN_CYCLES;
        repeat (limit) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles with %0d of %0d tests finished",
                 limit, tests_done, row_name.size());
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/wb_checker.sv ====
`default_nettype none

module wb_checker
    import isa_pkg::*, pipe_pkg::*;
#(
    parameter int NAME_BITS = 128
)
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_issue,
    input  wire   [NAME_BITS-1:0]  i_name,
    input  wire                    i_exp_valid,
    input  wire   [REG_ADDR_W-1:0] i_exp_dest,
    input  wire   [DATA_W-1:0]     i_exp_data,
    input  wire                    i_wb_valid,
    input  wire   [REG_ADDR_W-1:0] i_wb_dest,
    input  wire   [DATA_W-1:0]     i_wb_data,
    output int                     o_tests_done,
    output int                     o_tests_failed,
    output int                     o_stray_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAST = PIPE_LATENCY - 1;

    logic                  issue_q     [PIPE_LATENCY];
    logic [NAME_BITS-1:0]  name_q      [PIPE_LATENCY];
    logic                  exp_valid_q [PIPE_LATENCY];
    logic [REG_ADDR_W-1:0] exp_dest_q  [PIPE_LATENCY];
    logic [DATA_W-1:0]     exp_data_q  [PIPE_LATENCY];

    int tests_done   = 0;
    int tests_failed = 0;
    int stray_errors = 0;

    assign o_tests_done   = tests_done;
    assign o_tests_failed = tests_failed;
    assign o_stray_errors = stray_errors;

    // The expected values follow the instruction down a copy of the pipeline.
    always @(posedge i_clk)
    begin
        name_q[0]      <= i_name;
        exp_valid_q[0] <= i_exp_valid;
        exp_dest_q[0]  <= i_exp_dest;
        exp_data_q[0]  <= i_exp_data;
        for (int i = 1; i < PIPE_LATENCY; i++)
        begin
            name_q[i]      <= name_q[i-1];
            exp_valid_q[i] <= exp_valid_q[i-1];
            exp_dest_q[i]  <= exp_dest_q[i-1];
            exp_data_q[i]  <= exp_data_q[i-1];
        end
        if (!i_rst_n)
        begin
            for (int i = 0; i < PIPE_LATENCY; i++)
                issue_q[i] <= 1'b0;
        end
        else
        begin
            issue_q[0] <= i_issue;
            for (int i = 1; i < PIPE_LATENCY; i++)
                issue_q[i] <= issue_q[i-1];
        end
    end

    // Outputs are steady at the falling edge.
    always @(negedge i_clk)
    begin
        logic bad;
        bad = 1'b0;
        if (i_rst_n && issue_q[LAST])
        begin
            if (i_wb_valid !== exp_valid_q[LAST])
            begin
                $display("MISMATCH %s wb_valid expected %0b actual %0b",
                         name_q[LAST], exp_valid_q[LAST], i_wb_valid);
                bad = 1'b1;
            end
            else if (exp_valid_q[LAST])
            begin
                if (i_wb_dest !== exp_dest_q[LAST])
                begin
                    $display("MISMATCH %s wb_dest expected %0d actual %0d",
                             name_q[LAST], exp_dest_q[LAST], i_wb_dest);
                    bad = 1'b1;
                end
                if (i_wb_data !== exp_data_q[LAST])
                begin
                    $display("MISMATCH %s wb_data expected %08h actual %08h",
                             name_q[LAST], exp_data_q[LAST], i_wb_data);
                    bad = 1'b1;
                end
            end
            if (bad)
            begin
                tests_failed = tests_failed + 1;
                $display("FAIL %s", name_q[LAST]);
            end
            else
            begin
                $display("PASS %s", name_q[LAST]);
            end
            tests_done = tests_done + 1;
        end
        else if (i_rst_n && (i_wb_valid !== 1'b0))
        begin
            $display("ERROR: writeback to r%0d seen with no instruction due", i_wb_dest);
            stray_errors = stray_errors + 1;
        end
    end

endmodule

`default_nettype wire
